//--- hw/adpcma_pkg.sv
// shared sizes, register map and ADPCM-A tables; start/end blocks are in 256-byte units
`default_nettype none

package adpcma_pkg;

    // frame layout
    localparam int NUM_CH       = 6;
    localparam int SLOT_CYCLES  = 4;
    localparam int FRAME_CYCLES = NUM_CH * SLOT_CYCLES;  // 24
    localparam int CH_W         = 3;

    // widths
    localparam int ADDR_W     = 6;
    localparam int ROM_ADDR_W = 24;
    localparam int PTR_W      = ROM_ADDR_W + 1;  // byte address plus nibble select
    localparam int ACC_W      = 12;
    localparam int PCM_W      = 16;
    localparam int MIX_W      = 19;

    // register map, word addresses
    localparam logic [ADDR_W-1:0] REG_KEY      = 6'd0;   // bit 7 set means key off
    localparam logic [ADDR_W-1:0] REG_FLAG     = 6'd1;
    localparam logic [ADDR_W-1:0] REG_TL       = 6'd2;
    localparam logic [ADDR_W-1:0] REG_LVL_BASE = 6'd8;   // +ch, {l, r, -, level[4:0]}
    localparam logic [ADDR_W-1:0] REG_START_LO = 6'd16;
    localparam logic [ADDR_W-1:0] REG_START_HI = 6'd24;
    localparam logic [ADDR_W-1:0] REG_END_LO   = 6'd32;
    localparam logic [ADDR_W-1:0] REG_END_HI   = 6'd40;

    localparam int STEP_MAX_IDX = 48;

    localparam logic [10:0] STEP_TABLE [0:STEP_MAX_IDX] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // indexed by nibble magnitude
    localparam logic signed [4:0] INDEX_ADJ [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

endpackage

`default_nettype wire

//--- hw/adpcma_regs.sv
// wishbone classic slave, one wait state per access; unmapped and KEY reads return zero
`default_nettype none

module adpcma_regs (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 wb_cyc,
    input  wire logic                                 wb_stb,
    input  wire logic                                 wb_we,
    input  wire logic [adpcma_pkg::ADDR_W-1:0]        wb_adr,
    input  wire logic [7:0]                           wb_dat_w,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]        end_set,
    output logic      [7:0]                           wb_dat_r,
    output logic                                      wb_ack,
    output logic      [adpcma_pkg::NUM_CH-1:0]        key_on,
    output logic      [adpcma_pkg::NUM_CH-1:0]        key_off,
    output logic      [adpcma_pkg::NUM_CH*16-1:0]     start_blk,
    output logic      [adpcma_pkg::NUM_CH*16-1:0]     end_blk,
    output logic      [adpcma_pkg::NUM_CH*5-1:0]      ch_level,
    output logic      [adpcma_pkg::NUM_CH-1:0]        ch_pan_l,
    output logic      [adpcma_pkg::NUM_CH-1:0]        ch_pan_r,
    output logic      [5:0]                           total_level
);

    logic [7:0]  lvl  [adpcma_pkg::NUM_CH];
    logic [15:0] sblk [adpcma_pkg::NUM_CH];
    logic [15:0] eblk [adpcma_pkg::NUM_CH];
    logic [adpcma_pkg::NUM_CH-1:0] flags;
    logic [adpcma_pkg::NUM_CH-1:0] flag_clr;
    logic [adpcma_pkg::ADDR_W-1:0] grp;   // per-channel register group
    logic [adpcma_pkg::CH_W-1:0]   ch;
    logic ch_ok;
    logic req;
    logic wr;
    logic [7:0] rd_val;

    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign wr    = req && wb_we;
    assign grp   = {wb_adr[adpcma_pkg::ADDR_W-1:3], 3'b000};
    assign ch    = wb_adr[2:0];
    assign ch_ok = ch < adpcma_pkg::NUM_CH;
    assign flag_clr = (wr && wb_adr == adpcma_pkg::REG_FLAG) ?
                      wb_dat_w[adpcma_pkg::NUM_CH-1:0] : '0;

    for (genvar i = 0; i < adpcma_pkg::NUM_CH; i++) begin : g_flat
        assign start_blk[16*i +: 16] = sblk[i];
        assign end_blk[16*i +: 16]   = eblk[i];
        assign ch_level[5*i +: 5]    = lvl[i][4:0];
        assign ch_pan_l[i]           = lvl[i][7];
        assign ch_pan_r[i]           = lvl[i][6];
    end

    always_comb begin
        rd_val = '0;
        if (wb_adr == adpcma_pkg::REG_FLAG) rd_val = 8'(flags);
        if (wb_adr == adpcma_pkg::REG_TL)   rd_val = 8'(total_level);
        if (ch_ok) begin
            case (grp)
                adpcma_pkg::REG_LVL_BASE: rd_val = lvl[ch];
                adpcma_pkg::REG_START_LO: rd_val = sblk[ch][7:0];
                adpcma_pkg::REG_START_HI: rd_val = sblk[ch][15:8];
                adpcma_pkg::REG_END_LO:   rd_val = eblk[ch][7:0];
                adpcma_pkg::REG_END_HI:   rd_val = eblk[ch][15:8];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            key_on      <= '0;
            key_off     <= '0;
            flags       <= '0;
            total_level <= '0;
            for (int i = 0; i < adpcma_pkg::NUM_CH; i++) begin
                lvl[i]  <= '0;
                sblk[i] <= '0;
                eblk[i] <= '0;
            end
        end else begin
            wb_ack  <= req;
            key_on  <= '0;   // pulses last one cycle
            key_off <= '0;
            flags   <= (flags & ~flag_clr) | end_set;  // set beats clear
            if (wr) begin
                if (wb_adr == adpcma_pkg::REG_KEY) begin
                    if (wb_dat_w[7]) key_off <= wb_dat_w[adpcma_pkg::NUM_CH-1:0];
                    else             key_on  <= wb_dat_w[adpcma_pkg::NUM_CH-1:0];
                end
                if (wb_adr == adpcma_pkg::REG_TL) total_level <= wb_dat_w[5:0];
                if (ch_ok) begin
                    case (grp)
                        adpcma_pkg::REG_LVL_BASE: lvl[ch]        <= wb_dat_w;
                        adpcma_pkg::REG_START_LO: sblk[ch][7:0]  <= wb_dat_w;
                        adpcma_pkg::REG_START_HI: sblk[ch][15:8] <= wb_dat_w;
                        adpcma_pkg::REG_END_LO:   eblk[ch][7:0]  <= wb_dat_w;
                        adpcma_pkg::REG_END_HI:   eblk[ch][15:8] <= wb_dat_w;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= rd_val;
    end

    // ack only answers a cycle the master started
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

//--- hw/adpcma_addr_cnt.sv
// rom with fixed one-cycle latency; end block must not lie below start block
`default_nettype none

module adpcma_addr_cnt (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]         key_on,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]         key_off,
    input  wire logic [adpcma_pkg::NUM_CH*16-1:0]      start_blk,
    input  wire logic [adpcma_pkg::NUM_CH*16-1:0]      end_blk,
    input  wire logic [7:0]                            rom_data,
    output logic      [adpcma_pkg::ROM_ADDR_W-1:0]     rom_addr,
    output logic                                       rom_oe_n,
    output logic                                       nib_valid,
    output logic      [3:0]                            nib,
    output logic      [adpcma_pkg::CH_W-1:0]           nib_ch,
    output logic      [adpcma_pkg::NUM_CH-1:0]         ch_clear,
    output logic      [adpcma_pkg::NUM_CH-1:0]         end_set,
    output logic      [adpcma_pkg::CH_W-1:0]           slot_ch,
    output logic      [1:0]                            slot_phase
);

    logic [4:0] frame_cnt;
    logic [adpcma_pkg::PTR_W-1:0] ptr [adpcma_pkg::NUM_CH];
    logic [adpcma_pkg::PTR_W-1:0] cur_ptr;
    logic [adpcma_pkg::NUM_CH-1:0] active;
    logic [adpcma_pkg::NUM_CH-1:0] key_evt;
    logic rd_pend;   // rom answers this cycle
    logic at_end;

    assign slot_ch    = adpcma_pkg::CH_W'(frame_cnt / adpcma_pkg::SLOT_CYCLES);
    assign slot_phase = 2'(frame_cnt % adpcma_pkg::SLOT_CYCLES);
    assign key_evt    = key_on | key_off;
    assign cur_ptr    = ptr[slot_ch];

    assign rom_addr  = cur_ptr[adpcma_pkg::PTR_W-1:1];
    assign rom_oe_n  = !(slot_phase == 2'd0 && active[slot_ch]);
    assign nib_valid = rd_pend && !key_evt[slot_ch];   // a key event drops the read
    assign nib       = cur_ptr[0] ? rom_data[3:0] : rom_data[7:4];
    assign nib_ch    = slot_ch;
    assign ch_clear  = key_on;

    // low nibble of the last byte in the end block
    assign at_end = cur_ptr[0] &&
                    cur_ptr[adpcma_pkg::PTR_W-1:1] == {end_blk[16*slot_ch +: 16], 8'hff};

    always_comb begin
        end_set = '0;
        if (nib_valid && at_end) end_set[slot_ch] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            active    <= '0;
            rd_pend   <= 1'b0;
            for (int i = 0; i < adpcma_pkg::NUM_CH; i++) ptr[i] <= '0;
        end else begin
            frame_cnt <= (frame_cnt == 5'(adpcma_pkg::FRAME_CYCLES - 1)) ? '0 : frame_cnt + 5'd1;
            rd_pend   <= !rom_oe_n && !key_evt[slot_ch];
            if (nib_valid) begin
                ptr[slot_ch] <= cur_ptr + 1'b1;
                if (at_end) active[slot_ch] <= 1'b0;
            end
            for (int i = 0; i < adpcma_pkg::NUM_CH; i++) begin
                if (key_on[i]) begin
                    ptr[i]    <= {start_blk[16*i +: 16], 9'd0};  // 256 bytes = 512 nibbles
                    active[i] <= 1'b1;
                end
                if (key_off[i]) active[i] <= 1'b0;
            end
        end
    end

    // one-cycle strobe at phase 0 only
    assert property (@(posedge clk) disable iff (!rst_n)
        !rom_oe_n |-> slot_phase == 2'd0 ##1 rom_oe_n);

    // reads stay inside the programmed sample
    assert property (@(posedge clk) disable iff (!rst_n)
        !rom_oe_n |-> rom_addr >= {start_blk[16*slot_ch +: 16], 8'h00} &&
                      rom_addr <= {end_blk[16*slot_ch +: 16], 8'hff});

endmodule

`default_nettype wire

//--- hw/adpcma_decoder.sv
// one nibble per cycle at most; clear takes priority over a nibble for the same channel
`default_nettype none

module adpcma_decoder (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   nib_valid,
    input  wire logic [3:0]                             nib,
    input  wire logic [adpcma_pkg::CH_W-1:0]            nib_ch,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]          ch_clear,
    output logic                                        pcm_valid,
    output logic signed [adpcma_pkg::PCM_W-1:0]         pcm,
    output logic        [adpcma_pkg::CH_W-1:0]          pcm_ch
);

    logic [adpcma_pkg::ACC_W-1:0] acc [adpcma_pkg::NUM_CH];
    logic [5:0]                   idx [adpcma_pkg::NUM_CH];
    logic [2:0]  mag;
    logic [10:0] step;
    logic [14:0] prod;                        // (2m+1)*step, max 23280
    logic [adpcma_pkg::ACC_W-1:0] diff;
    logic [adpcma_pkg::ACC_W-1:0] acc_new;
    logic signed [6:0] idx_sum;
    logic [5:0] idx_new;

    always_comb begin
        mag     = nib[2:0];
        step    = adpcma_pkg::STEP_TABLE[idx[nib_ch]];
        prod    = {mag, 1'b1} * step;
        diff    = prod[14:3];                 // divide by 8
        acc_new = nib[3] ? acc[nib_ch] - diff : acc[nib_ch] + diff;  // wraps at 12 bits
        idx_sum = signed'({1'b0, idx[nib_ch]}) + adpcma_pkg::INDEX_ADJ[mag];
        if (idx_sum < 0)
            idx_new = '0;
        else if (idx_sum > adpcma_pkg::STEP_MAX_IDX)
            idx_new = 6'(adpcma_pkg::STEP_MAX_IDX);
        else
            idx_new = idx_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_valid <= 1'b0;
            for (int i = 0; i < adpcma_pkg::NUM_CH; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
        end else begin
            pcm_valid <= nib_valid;
            if (nib_valid) begin
                acc[nib_ch] <= acc_new;
                idx[nib_ch] <= idx_new;
            end
            for (int i = 0; i < adpcma_pkg::NUM_CH; i++) begin
                if (ch_clear[i]) begin
                    acc[i] <= '0;
                    idx[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (nib_valid) begin
            pcm    <= {acc_new, 4'b0000};
            pcm_ch <= nib_ch;
        end
    end

    // index stays inside the step table
    assert property (@(posedge clk) disable iff (!rst_n)
        pcm_valid |-> idx[pcm_ch] <= adpcma_pkg::STEP_MAX_IDX);

endmodule

`default_nettype wire

//--- hw/adpcma_gain.sv
// attenuation in 6 dB steps only, finer 0.75 dB units are truncated away
`default_nettype none

module adpcma_gain (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   pcm_valid,
    input  wire logic signed [adpcma_pkg::PCM_W-1:0]    pcm,
    input  wire logic [adpcma_pkg::CH_W-1:0]            pcm_ch,
    input  wire logic [adpcma_pkg::NUM_CH*5-1:0]        ch_level,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]          ch_pan_l,
    input  wire logic [adpcma_pkg::NUM_CH-1:0]          ch_pan_r,
    input  wire logic [5:0]                             total_level,
    output logic                                        gain_valid,
    output logic signed [adpcma_pkg::PCM_W-1:0]         gain_l,
    output logic signed [adpcma_pkg::PCM_W-1:0]         gain_r,
    output logic        [adpcma_pkg::CH_W-1:0]          gain_slot
);

    logic [4:0] lvl;
    logic [6:0] att;     // 0..94
    logic [3:0] sh;
    logic signed [adpcma_pkg::PCM_W-1:0] shifted;

    always_comb begin
        lvl     = ch_level[5*pcm_ch +: 5];
        att     = 7'(5'd31 - lvl) + 7'(6'd63 - total_level);
        sh      = att[6:3];
        shifted = pcm >>> sh;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) gain_valid <= 1'b0;
        else        gain_valid <= pcm_valid;
    end

    always_ff @(posedge clk) begin
        if (pcm_valid) begin
            gain_l    <= ch_pan_l[pcm_ch] ? shifted : '0;
            gain_r    <= ch_pan_r[pcm_ch] ? shifted : '0;
            gain_slot <= pcm_ch;
        end
    end

endmodule

`default_nettype wire

//--- hw/adpcma_mixer.sv
// one stereo sample per 24-cycle frame, output cannot be stalled
`default_nettype none

module adpcma_mixer (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   gain_valid,
    input  wire logic signed [adpcma_pkg::PCM_W-1:0]    gain_l,
    input  wire logic signed [adpcma_pkg::PCM_W-1:0]    gain_r,
    input  wire logic [adpcma_pkg::CH_W-1:0]            gain_slot,
    input  wire logic [adpcma_pkg::CH_W-1:0]            slot_ch,
    input  wire logic [1:0]                             slot_phase,
    output logic signed [adpcma_pkg::PCM_W-1:0]         sample_l,
    output logic signed [adpcma_pkg::PCM_W-1:0]         sample_r,
    output logic                                        sample_valid
);

    logic signed [adpcma_pkg::MIX_W-1:0] sum_l, sum_r;
    logic signed [adpcma_pkg::MIX_W-1:0] nxt_l, nxt_r;
    logic add_en;
    logic frame_end;

    function automatic logic signed [adpcma_pkg::PCM_W-1:0] sat(
        input logic signed [adpcma_pkg::MIX_W-1:0] v
    );
        if (&v[adpcma_pkg::MIX_W-1:adpcma_pkg::PCM_W-1] ||
            ~|v[adpcma_pkg::MIX_W-1:adpcma_pkg::PCM_W-1])
            return v[adpcma_pkg::PCM_W-1:0];
        return v[adpcma_pkg::MIX_W-1] ? {1'b1, {(adpcma_pkg::PCM_W-1){1'b0}}}
                                      : {1'b0, {(adpcma_pkg::PCM_W-1){1'b1}}};
    endfunction

    assign add_en    = gain_valid && slot_phase == 2'(adpcma_pkg::SLOT_CYCLES - 1);
    assign frame_end = slot_ch == adpcma_pkg::CH_W'(adpcma_pkg::NUM_CH - 1) &&
                       slot_phase == 2'(adpcma_pkg::SLOT_CYCLES - 1);
    assign nxt_l = add_en ? sum_l + adpcma_pkg::MIX_W'(gain_l) : sum_l;
    assign nxt_r = add_en ? sum_r + adpcma_pkg::MIX_W'(gain_r) : sum_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_l        <= '0;
            sum_r        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_end;
            sum_l        <= frame_end ? '0 : nxt_l;  // restart each frame
            sum_r        <= frame_end ? '0 : nxt_r;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            sample_l <= sat(nxt_l);
            sample_r <= sat(nxt_r);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid);

    // pipeline lands on the last cycle of its own slot
    assert property (@(posedge clk) disable iff (!rst_n)
        gain_valid |-> gain_slot == slot_ch && slot_phase == 2'(adpcma_pkg::SLOT_CYCLES - 1));

endmodule

`default_nettype wire

//--- hw/adpcma_top.sv
// six-channel ADPCM-A engine at clk rate, fixed 24-cycle frame, no back-pressure
`default_nettype none

module adpcma_top (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   wb_cyc,
    input  wire logic                                   wb_stb,
    input  wire logic                                   wb_we,
    input  wire logic [adpcma_pkg::ADDR_W-1:0]          wb_adr,
    input  wire logic [7:0]                             wb_dat_w,
    output logic      [7:0]                             wb_dat_r,
    output logic                                        wb_ack,
    output logic      [adpcma_pkg::ROM_ADDR_W-1:0]      rom_addr,
    output logic                                        rom_oe_n,
    input  wire logic [7:0]                             rom_data,
    output logic signed [adpcma_pkg::PCM_W-1:0]         sample_l,
    output logic signed [adpcma_pkg::PCM_W-1:0]         sample_r,
    output logic                                        sample_valid
);

    logic [adpcma_pkg::NUM_CH-1:0]      key_on, key_off, end_set, ch_clear;
    logic [adpcma_pkg::NUM_CH*16-1:0]   start_blk, end_blk;
    logic [adpcma_pkg::NUM_CH*5-1:0]    ch_level;
    logic [adpcma_pkg::NUM_CH-1:0]      ch_pan_l, ch_pan_r;
    logic [5:0]                         total_level;
    logic                               nib_valid, pcm_valid, gain_valid;
    logic [3:0]                         nib;
    logic [adpcma_pkg::CH_W-1:0]        nib_ch, pcm_ch, gain_slot, slot_ch;
    logic [1:0]                         slot_phase;
    logic signed [adpcma_pkg::PCM_W-1:0] pcm, gain_l, gain_r;

    // host side
    adpcma_regs regs_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .end_set,
        .wb_dat_r, .wb_ack, .key_on, .key_off, .start_blk, .end_blk,
        .ch_level, .ch_pan_l, .ch_pan_r, .total_level
    );

    // fetch, decode, attenuate
    adpcma_addr_cnt addr_cnt_i (
        .clk, .rst_n, .key_on, .key_off, .start_blk, .end_blk, .rom_data,
        .rom_addr, .rom_oe_n, .nib_valid, .nib, .nib_ch, .ch_clear, .end_set,
        .slot_ch, .slot_phase
    );

    adpcma_decoder decoder_i (
        .clk, .rst_n, .nib_valid, .nib, .nib_ch, .ch_clear,
        .pcm_valid, .pcm, .pcm_ch
    );

    adpcma_gain gain_i (
        .clk, .rst_n, .pcm_valid, .pcm, .pcm_ch, .ch_level, .ch_pan_l, .ch_pan_r,
        .total_level, .gain_valid, .gain_l, .gain_r, .gain_slot
    );

    // audio out
    adpcma_mixer mixer_i (
        .clk, .rst_n, .gain_valid, .gain_l, .gain_r, .gain_slot, .slot_ch, .slot_phase,
        .sample_l, .sample_r, .sample_valid
    );

endmodule

`default_nettype wire

//--- verif/adpcma_tb.sv
// ROM model holds only 16 blocks (4 KiB), so sample blocks must stay below block 16
`default_nettype none

module adpcma_tb;

    localparam int PLAYED_NIBBLES = 2 * 512 + 6 * 100 + 5 * 20 + 5 * 20;
    localparam longint WATCHDOG_TIME =
        longint'(PLAYED_NIBBLES + 20) * adpcma_pkg::FRAME_CYCLES * 100;

    logic clk, rst_n;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [adpcma_pkg::ADDR_W-1:0] wb_adr;
    logic [7:0] wb_dat_w, wb_dat_r, rom_data;
    logic [adpcma_pkg::ROM_ADDR_W-1:0] rom_addr;
    logic rom_oe_n, sample_valid;
    logic signed [adpcma_pkg::PCM_W-1:0] sample_l, sample_r;
    string test_name;
    logic [7:0] mem [4096];
    logic [19:0] lfsr;

    // reference model state
    int mf;                                   // frame cycle
    logic [adpcma_pkg::PTR_W-1:0] mptr [6];
    logic [11:0] macc [6];
    int midx [6];
    logic [7:0] mlvl [6];
    logic [15:0] msblk [6];
    logic [15:0] meblk [6];
    logic [5:0] mtl, mact, mflag, mkon, mkoff;
    logic mrd, mpv, msv;
    logic signed [15:0] mpcm, exp_l, exp_r;
    int msum_l, msum_r;
    logic [7:0] mrdata;                       // expected read data
    logic [2:0] mslot;
    logic exp_oe_n;
    logic [23:0] exp_addr;

    adpcma_top adpcma_top_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .rom_addr, .rom_oe_n, .rom_data, .sample_l, .sample_r, .sample_valid
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^20 + x^17 + 1
    function automatic logic [19:0] lfsr_step(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    function automatic logic signed [15:0] clamp16(input int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return 16'(v);
    endfunction

    task automatic fail_check(input string check, input int exp_v, input int act_v);
        $display("[FAIL] %s: %s expected %0d actual %0d", test_name, check, exp_v, act_v);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [7:0] dat,
                              output logic [7:0] rd);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do @(posedge clk); while (!wb_ack);
        rd = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic write_reg(input logic [5:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input logic [5:0] adr, output logic [7:0] rd);
        bus_access(1'b0, adr, 8'h00, rd);
    endtask

    task automatic program_channel(input int ch, input logic [15:0] sb, input logic [15:0] eb,
                                   input logic [7:0] lvl);
        write_reg(6'(adpcma_pkg::REG_LVL_BASE + ch), lvl);
        write_reg(6'(adpcma_pkg::REG_START_LO + ch), sb[7:0]);
        write_reg(6'(adpcma_pkg::REG_START_HI + ch), sb[15:8]);
        write_reg(6'(adpcma_pkg::REG_END_LO + ch), eb[7:0]);
        write_reg(6'(adpcma_pkg::REG_END_HI + ch), eb[15:8]);
    endtask

    task automatic wait_frames(input int n);
        repeat (n * adpcma_pkg::FRAME_CYCLES) @(posedge clk);
    endtask

    // poll until every flag in mask is set
    task automatic wait_flags(input logic [5:0] mask);
        logic [7:0] f;
        f = '0;
        while ((f[5:0] & mask) != mask) begin
            wait_frames(1);
            read_reg(adpcma_pkg::REG_FLAG, f);
        end
    endtask

    always @(posedge clk) begin
        if (!rom_oe_n) rom_data <= mem[rom_addr[11:0]];   // one-cycle latency
    end

    always @(posedge clk or negedge rst_n) begin : ref_model
        int s;
        int ph;
        int diff;
        int sh;
        logic [7:0] b;
        logic [3:0] n;
        logic [2:0] c;
        logic req;
        if (!rst_n) begin
            mf = 0;
            {mtl, mact, mflag, mkon, mkoff, mrd, mpv, msv} = '0;
            {msum_l, msum_r} = '0;
            for (int i = 0; i < 6; i++) begin
                {mlvl[i], msblk[i], meblk[i], mptr[i], macc[i]} = '0;
                midx[i] = 0;
            end
        end else begin
            s = mf / 4;
            ph = mf % 4;
            c = wb_adr[2:0];
            req = wb_cyc && wb_stb && !wb_ack;
            if (req && !wb_we) begin
                if (wb_adr[5:3] != 3'd0 && c > 3'd5)
                    mrdata = 8'h00;
                else
                    case (wb_adr[5:3])
                        3'd0: mrdata = (wb_adr == 6'd1) ? 8'(mflag) :
                                       (wb_adr == 6'd2) ? 8'(mtl) : 8'h00;
                        3'd1: mrdata = mlvl[c];
                        3'd2: mrdata = msblk[c][7:0];
                        3'd3: mrdata = msblk[c][15:8];
                        3'd4: mrdata = meblk[c][7:0];
                        3'd5: mrdata = meblk[c][15:8];
                        default: mrdata = 8'h00;
                    endcase
            end
            if (req && wb_we && wb_adr == 6'd1) mflag = mflag & ~wb_dat_w[5:0];
            // attenuate and pan the nibble decoded one cycle earlier
            if (mpv) begin
                sh = (31 - int'(mlvl[s][4:0]) + 63 - int'(mtl)) / 8;
                if (mlvl[s][7]) msum_l += int'(mpcm >>> sh);
                if (mlvl[s][6]) msum_r += int'(mpcm >>> sh);
                mpv = 1'b0;
            end
            if (ph == 0) mrd = mact[s] && !(mkon[s] || mkoff[s]);
            if (ph == 1 && mrd && !(mkon[s] || mkoff[s])) begin
                b = mem[mptr[s][12:1]];
                n = mptr[s][0] ? b[3:0] : b[7:4];   // high nibble first
                diff = (2 * int'(n[2:0]) + 1) * int'(adpcma_pkg::STEP_TABLE[midx[s]]) / 8;
                macc[s] = n[3] ? macc[s] - 12'(diff) : macc[s] + 12'(diff);
                midx[s] = midx[s] + int'(adpcma_pkg::INDEX_ADJ[n[2:0]]);
                if (midx[s] < 0) midx[s] = 0;
                if (midx[s] > adpcma_pkg::STEP_MAX_IDX) midx[s] = adpcma_pkg::STEP_MAX_IDX;
                mpcm = {macc[s], 4'h0};
                mpv = 1'b1;
                if (mptr[s][0] && mptr[s][24:1] == {meblk[s], 8'hff}) begin
                    mact[s] = 1'b0;
                    mflag[s] = 1'b1;
                end
                mptr[s] = mptr[s] + 1'b1;
            end
            for (int i = 0; i < 6; i++) begin
                if (mkon[i]) begin
                    mptr[i] = {msblk[i], 9'd0};
                    mact[i] = 1'b1;
                    macc[i] = '0;
                    midx[i] = 0;
                end
                if (mkoff[i]) mact[i] = 1'b0;
            end
            msv = (mf == adpcma_pkg::FRAME_CYCLES - 1);
            if (msv) begin
                exp_l = clamp16(msum_l);
                exp_r = clamp16(msum_r);
                msum_l = 0;
                msum_r = 0;
            end
            mf = msv ? 0 : mf + 1;
            // writes land now, key pulses act at the next edge
            mkon = '0;
            mkoff = '0;
            if (req && wb_we) begin
                if (wb_adr == 6'd0 && wb_dat_w[7]) mkoff = wb_dat_w[5:0];
                if (wb_adr == 6'd0 && !wb_dat_w[7]) mkon = wb_dat_w[5:0];
                if (wb_adr == 6'd2) mtl = wb_dat_w[5:0];
                if (c < 3'd6) begin
                    case (wb_adr[5:3])
                        3'd1: mlvl[c] = wb_dat_w;
                        3'd2: msblk[c][7:0] = wb_dat_w;
                        3'd3: msblk[c][15:8] = wb_dat_w;
                        3'd4: meblk[c][7:0] = wb_dat_w;
                        3'd5: meblk[c][15:8] = wb_dat_w;
                        default: ;
                    endcase
                end
            end
        end
    end

    assign mslot    = 3'(mf / 4);
    assign exp_oe_n = !(mf % 4 == 0 && mact[mslot]);
    assign exp_addr = mptr[mslot][24:1];

    assert property (@(posedge clk) disable iff (!rst_n) rom_oe_n == exp_oe_n)
        else fail_check("rom strobe", $sampled(exp_oe_n), $sampled(rom_oe_n));
    assert property (@(posedge clk) disable iff (!rst_n) !rom_oe_n |-> rom_addr == exp_addr)
        else fail_check("rom address", $sampled(exp_addr), $sampled(rom_addr));
    assert property (@(posedge clk) disable iff (!rst_n) sample_valid == msv)
        else fail_check("sample valid", $sampled(msv), $sampled(sample_valid));
    assert property (@(posedge clk) disable iff (!rst_n) sample_valid |-> sample_l == exp_l)
        else fail_check("left sample", $sampled(exp_l), $sampled(sample_l));
    assert property (@(posedge clk) disable iff (!rst_n) sample_valid |-> sample_r == exp_r)
        else fail_check("right sample", $sampled(exp_r), $sampled(sample_r));
    assert property (@(posedge clk) disable iff (!rst_n) wb_ack && !wb_we |-> wb_dat_r == mrdata)
        else fail_check("register read", $sampled(mrdata), $sampled(wb_dat_r));
    assert property (@(posedge clk) disable iff (!rst_n) $rose(wb_stb) |=> wb_ack)
        else fail_check("ack delay", 1, 0);
    assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else fail_check("ack length", 0, 1);

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("timeout: the tests did not finish in the expected time");
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin : stimulus
        logic [7:0] rd;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        rom_data  = '0;
        rst_n     = 1'b0;
        test_name = "reset";
        lfsr = 20'd82307;
        for (int a = 0; a < 4096; a++) begin
            for (int k = 0; k < 8; k++) begin
                lfsr = lfsr_step(lfsr);
                mem[a] = {mem[a][6:0], lfsr[0]};
            end
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "register access";
        for (int ch = 0; ch < 6; ch++) begin
            for (int g = 1; g < 6; g++) begin   // level, start and end groups
                write_reg(6'(8 * g + ch), 8'(37 * g + 11 * ch));
                read_reg(6'(8 * g + ch), rd);
            end
        end
        write_reg(adpcma_pkg::REG_TL, 8'h2a);
        read_reg(adpcma_pkg::REG_TL, rd);
        read_reg(6'd7, rd);

        test_name = "address sequence";
        program_channel(0, 16'd1, 16'd1, 8'hdf);
        program_channel(1, 16'd2, 16'd2, 8'hdf);
        write_reg(adpcma_pkg::REG_KEY, 8'h03);
        wait_flags(6'h03);
        test_name = "end flag";
        write_reg(adpcma_pkg::REG_FLAG, 8'h01);
        read_reg(adpcma_pkg::REG_FLAG, rd);
        wait_frames(3);

        test_name = "decoded mix";
        write_reg(adpcma_pkg::REG_TL, 8'h3f);   // all full level to reach saturation
        for (int ch = 0; ch < 6; ch++) begin
            program_channel(ch, 16'(4 + ch), 16'(4 + ch), 8'hdf);
        end
        write_reg(adpcma_pkg::REG_KEY, 8'h3f);
        wait_frames(60);
        write_reg(adpcma_pkg::REG_TL, 8'h32);
        for (int ch = 0; ch < 6; ch++) begin
            write_reg(6'(adpcma_pkg::REG_LVL_BASE + ch), 8'(8'hc0 + 5 * ch));
        end
        wait_frames(40);

        test_name = "pan and key off";
        write_reg(6'(adpcma_pkg::REG_LVL_BASE + 2), 8'h9f);   // left only
        write_reg(adpcma_pkg::REG_KEY, 8'h88);
        wait_frames(20);

        test_name = "retrigger";
        write_reg(adpcma_pkg::REG_KEY, 8'h01);
        wait_frames(20);
        write_reg(adpcma_pkg::REG_KEY, 8'hbf);
        wait_frames(3);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- adpcma.f
hw/adpcma_pkg.sv
hw/adpcma_regs.sv
hw/adpcma_addr_cnt.sv
hw/adpcma_decoder.sv
hw/adpcma_gain.sv
hw/adpcma_mixer.sv
hw/adpcma_top.sv
verif/adpcma_tb.sv
